//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_axi_write_xbar
FLIST     := axi_write_xbar.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)

//--- axi_write_xbar.f
logic/axi_xbar_pkg.sv
logic/axi_write_lock_pkg.sv
logic/aw_arbiter.sv
logic/w_router.sv
logic/b_return.sv
logic/axi_write_xbar.sv
tb/xbar_slave_model.sv
tb/tb_axi_write_xbar.sv

//--- logic/aw_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module aw_arbiter
  import axi_xbar_pkg::*;
  import axi_write_lock_pkg::*;
#(
  parameter int ID_WIDTH = 4,
  parameter int ADDR_WIDTH = 32,
  localparam int SID_WIDTH = ID_WIDTH + TAG_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [ID_WIDTH-1:0]   m0_awid,
  input  logic [ADDR_WIDTH-1:0] m0_awaddr,
  input  logic [7:0]            m0_awlen,
  input  logic                  m0_awvalid,
  output logic                  m0_awready,
  input  logic [ID_WIDTH-1:0]   m1_awid,
  input  logic [ADDR_WIDTH-1:0] m1_awaddr,
  input  logic [7:0]            m1_awlen,
  input  logic                  m1_awvalid,
  output logic                  m1_awready,
  output logic [SID_WIDTH-1:0]  s0_awid,
  output logic [ADDR_WIDTH-1:0] s0_awaddr,
  output logic [7:0]            s0_awlen,
  output logic                  s0_awvalid,
  input  logic                  s0_awready,
  output logic [SID_WIDTH-1:0]  s1_awid,
  output logic [ADDR_WIDTH-1:0] s1_awaddr,
  output logic [7:0]            s1_awlen,
  output logic                  s1_awvalid,
  input  logic                  s1_awready,
  output logic [SID_WIDTH-1:0]  s2_awid,
  output logic [ADDR_WIDTH-1:0] s2_awaddr,
  output logic [7:0]            s2_awlen,
  output logic                  s2_awvalid,
  input  logic                  s2_awready,
  input  write_lock_t           lock,
  output logic                  aw_fire,
  output slave_sel_t            aw_slave,
  output master_sel_t           aw_master
);

  logic                  idle;
  logic                  prio_m1;
  logic                  hold_valid;
  master_sel_t           hold_master;
  logic                  gnt_valid;
  master_sel_t           grant;
  logic [ID_WIDTH-1:0]   sel_id;
  logic [ADDR_WIDTH-1:0] sel_addr;
  logic [7:0]            sel_len;
  logic                  sel_ready;
  logic                  req_valid;

  assign idle = (lock == WLOCK_NO);

  // A presented grant stays put until its transfer
  always_comb begin
    gnt_valid = 1'b1;
    grant = MASTER_0;
    if (hold_valid)
      grant = hold_master;
    else if (m0_awvalid && m1_awvalid)
      grant = prio_m1 ? MASTER_1 : MASTER_0;
    else if (m1_awvalid)
      grant = MASTER_1;
    else if (!m0_awvalid)
      gnt_valid = 1'b0;
  end

  assign sel_id   = (grant == MASTER_1) ? m1_awid : m0_awid;
  assign sel_addr = (grant == MASTER_1) ? m1_awaddr : m0_awaddr;
  assign sel_len  = (grant == MASTER_1) ? m1_awlen : m0_awlen;

  // Regions 2 and 3 fall to the default slave
  always_comb begin
    case (sel_addr[17:16])
      2'd0:    aw_slave = SLAVE_0;
      2'd1:    aw_slave = SLAVE_1;
      default: aw_slave = SLAVE_2;
    endcase
  end

  always_comb begin
    case (aw_slave)
      SLAVE_0: sel_ready = s0_awready;
      SLAVE_1: sel_ready = s1_awready;
      default: sel_ready = s2_awready;
    endcase
  end

  assign req_valid = idle && gnt_valid;
  assign aw_fire   = req_valid && sel_ready;
  assign aw_master = grant;

  assign m0_awready = aw_fire && (grant == MASTER_0);
  assign m1_awready = aw_fire && (grant == MASTER_1);

  assign s0_awid    = {sel_id, TAG_BITS'(grant)};
  assign s0_awaddr  = sel_addr;
  assign s0_awlen   = sel_len;
  assign s0_awvalid = req_valid && (aw_slave == SLAVE_0);
  assign s1_awid    = {sel_id, TAG_BITS'(grant)};
  assign s1_awaddr  = sel_addr;
  assign s1_awlen   = sel_len;
  assign s1_awvalid = req_valid && (aw_slave == SLAVE_1);
  assign s2_awid    = {sel_id, TAG_BITS'(grant)};
  assign s2_awaddr  = sel_addr;
  assign s2_awlen   = sel_len;
  assign s2_awvalid = req_valid && (aw_slave == SLAVE_2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prio_m1 <= 1'b0;
      hold_valid <= 1'b0;
      hold_master <= MASTER_0;
    end else begin
      if (aw_fire) begin
        // Other master goes first next time
        prio_m1 <= (grant == MASTER_0);
        hold_valid <= 1'b0;
      end else if (req_valid) begin
        hold_valid <= 1'b1;
        hold_master <= grant;
      end
    end
  end

  a_awready_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (m0_awready || m1_awready) |-> (lock == WLOCK_NO));

endmodule

`default_nettype wire

//--- logic/axi_write_lock_pkg.sv
`default_nettype none

package axi_write_lock_pkg;

  // One write in flight
  // Sk while data moves to slave k, Sk_WVALID while its response is pending
  typedef enum logic [2:0] {
    WLOCK_NO        = 3'd0,
    WLOCK_S0        = 3'd1,
    WLOCK_S1        = 3'd2,
    WLOCK_S2        = 3'd3,
    WLOCK_S0_WVALID = 3'd4,
    WLOCK_S1_WVALID = 3'd5,
    WLOCK_S2_WVALID = 3'd6
  } write_lock_t;

endpackage

`default_nettype wire

//--- logic/axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_xbar
  import axi_xbar_pkg::*;
  import axi_write_lock_pkg::*;
#(
  parameter int ID_WIDTH = 4,
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  localparam int SID_WIDTH = ID_WIDTH + TAG_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Master 0
  input  logic [ID_WIDTH-1:0]   m0_awid,
  input  logic [ADDR_WIDTH-1:0] m0_awaddr,
  input  logic [7:0]            m0_awlen,
  input  logic                  m0_awvalid,
  output logic                  m0_awready,
  input  logic [DATA_WIDTH-1:0] m0_wdata,
  input  logic                  m0_wlast,
  input  logic                  m0_wvalid,
  output logic                  m0_wready,
  output logic [ID_WIDTH-1:0]   m0_bid,
  output logic [1:0]            m0_bresp,
  output logic                  m0_bvalid,
  input  logic                  m0_bready,
  // Master 1
  input  logic [ID_WIDTH-1:0]   m1_awid,
  input  logic [ADDR_WIDTH-1:0] m1_awaddr,
  input  logic [7:0]            m1_awlen,
  input  logic                  m1_awvalid,
  output logic                  m1_awready,
  input  logic [DATA_WIDTH-1:0] m1_wdata,
  input  logic                  m1_wlast,
  input  logic                  m1_wvalid,
  output logic                  m1_wready,
  output logic [ID_WIDTH-1:0]   m1_bid,
  output logic [1:0]            m1_bresp,
  output logic                  m1_bvalid,
  input  logic                  m1_bready,
  // Slave 0
  output logic [SID_WIDTH-1:0]  s0_awid,
  output logic [ADDR_WIDTH-1:0] s0_awaddr,
  output logic [7:0]            s0_awlen,
  output logic                  s0_awvalid,
  input  logic                  s0_awready,
  output logic [DATA_WIDTH-1:0] s0_wdata,
  output logic                  s0_wlast,
  output logic                  s0_wvalid,
  input  logic                  s0_wready,
  input  logic [SID_WIDTH-1:0]  s0_bid,
  input  logic [1:0]            s0_bresp,
  input  logic                  s0_bvalid,
  output logic                  s0_bready,
  // Slave 1
  output logic [SID_WIDTH-1:0]  s1_awid,
  output logic [ADDR_WIDTH-1:0] s1_awaddr,
  output logic [7:0]            s1_awlen,
  output logic                  s1_awvalid,
  input  logic                  s1_awready,
  output logic [DATA_WIDTH-1:0] s1_wdata,
  output logic                  s1_wlast,
  output logic                  s1_wvalid,
  input  logic                  s1_wready,
  input  logic [SID_WIDTH-1:0]  s1_bid,
  input  logic [1:0]            s1_bresp,
  input  logic                  s1_bvalid,
  output logic                  s1_bready,
  // Slave 2, default region
  output logic [SID_WIDTH-1:0]  s2_awid,
  output logic [ADDR_WIDTH-1:0] s2_awaddr,
  output logic [7:0]            s2_awlen,
  output logic                  s2_awvalid,
  input  logic                  s2_awready,
  output logic [DATA_WIDTH-1:0] s2_wdata,
  output logic                  s2_wlast,
  output logic                  s2_wvalid,
  input  logic                  s2_wready,
  input  logic [SID_WIDTH-1:0]  s2_bid,
  input  logic [1:0]            s2_bresp,
  input  logic                  s2_bvalid,
  output logic                  s2_bready
);

  logic        aw_fire;
  slave_sel_t  aw_slave;
  master_sel_t aw_master;
  write_lock_t lock;
  logic        b_fire;

  aw_arbiter #(
    .ID_WIDTH(ID_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_aw_arbiter (.*);

  w_router #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_w_router (.*);

  b_return #(
    .ID_WIDTH(ID_WIDTH)
  ) u_b_return (.*);

endmodule

`default_nettype wire

//--- logic/axi_xbar_pkg.sv
`default_nettype none

package axi_xbar_pkg;

  // Source master carried in the low tag bits of a slave-side ID
  typedef enum logic [1:0] {
    MASTER_0 = 2'd0,
    MASTER_1 = 2'd1,
    MASTER_U = 2'd2
  } master_sel_t;

  // Write target, from address bits 17:16
  typedef enum logic [1:0] {
    SLAVE_0 = 2'd0,
    SLAVE_1 = 2'd1,
    SLAVE_2 = 2'd2
  } slave_sel_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Master tag width in the slave-side ID
  localparam int TAG_BITS = 4;

  function automatic master_sel_t master_of_tag(input logic [TAG_BITS-1:0] tag);
    master_sel_t m;
    case (tag)
      TAG_BITS'(0): m = MASTER_0;
      TAG_BITS'(1): m = MASTER_1;
      default:      m = MASTER_U;
    endcase
    return m;
  endfunction

endpackage

`default_nettype wire

//--- logic/b_return.sv
`timescale 1ns/1ps
`default_nettype none

module b_return
  import axi_xbar_pkg::*;
  import axi_write_lock_pkg::*;
#(
  parameter int ID_WIDTH = 4,
  localparam int SID_WIDTH = ID_WIDTH + TAG_BITS
) (
  input  write_lock_t          lock,
  input  logic [SID_WIDTH-1:0] s0_bid,
  input  logic [1:0]           s0_bresp,
  input  logic                 s0_bvalid,
  output logic                 s0_bready,
  input  logic [SID_WIDTH-1:0] s1_bid,
  input  logic [1:0]           s1_bresp,
  input  logic                 s1_bvalid,
  output logic                 s1_bready,
  input  logic [SID_WIDTH-1:0] s2_bid,
  input  logic [1:0]           s2_bresp,
  input  logic                 s2_bvalid,
  output logic                 s2_bready,
  output logic [ID_WIDTH-1:0]  m0_bid,
  output logic [1:0]           m0_bresp,
  output logic                 m0_bvalid,
  input  logic                 m0_bready,
  output logic [ID_WIDTH-1:0]  m1_bid,
  output logic [1:0]           m1_bresp,
  output logic                 m1_bvalid,
  input  logic                 m1_bready,
  output logic                 b_fire
);

  slave_sel_t           bsel;
  logic                 bsel_valid;
  logic [SID_WIDTH-1:0] sel_bid;
  logic [1:0]           sel_bresp;
  logic                 sel_bvalid;
  logic                 sel_bready;
  master_sel_t          bmaster;

  // Only a pending response state opens a slave's B channel
  always_comb begin
    bsel = SLAVE_0;
    bsel_valid = 1'b1;
    case (lock)
      WLOCK_S0_WVALID: bsel = SLAVE_0;
      WLOCK_S1_WVALID: bsel = SLAVE_1;
      WLOCK_S2_WVALID: bsel = SLAVE_2;
      default:         bsel_valid = 1'b0;
    endcase
  end

  always_comb begin
    sel_bid = '0;
    sel_bresp = 2'b00;
    sel_bvalid = 1'b0;
    if (bsel_valid) begin
      case (bsel)
        SLAVE_0: begin
          sel_bid = s0_bid;
          sel_bresp = s0_bresp;
          sel_bvalid = s0_bvalid;
        end
        SLAVE_1: begin
          sel_bid = s1_bid;
          sel_bresp = s1_bresp;
          sel_bvalid = s1_bvalid;
        end
        default: begin
          sel_bid = s2_bid;
          sel_bresp = s2_bresp;
          sel_bvalid = s2_bvalid;
        end
      endcase
    end
  end

  assign bmaster = master_of_tag(sel_bid[TAG_BITS-1:0]);

  // Unknown tag has no master to accept it
  assign sel_bready = ((bmaster == MASTER_0) && m0_bready) ||
                      ((bmaster == MASTER_1) && m1_bready);

  assign s0_bready = bsel_valid && (bsel == SLAVE_0) && sel_bready;
  assign s1_bready = bsel_valid && (bsel == SLAVE_1) && sel_bready;
  assign s2_bready = bsel_valid && (bsel == SLAVE_2) && sel_bready;

  always_comb begin
    m0_bid = '0;
    m0_bresp = 2'b00;
    m0_bvalid = 1'b0;
    m1_bid = '0;
    m1_bresp = 2'b00;
    m1_bvalid = 1'b0;
    case (bmaster)
      MASTER_0: begin
        m0_bid = sel_bid[SID_WIDTH-1:TAG_BITS];
        m0_bresp = sel_bresp;
        m0_bvalid = sel_bvalid;
      end
      MASTER_1: begin
        m1_bid = sel_bid[SID_WIDTH-1:TAG_BITS];
        m1_bresp = sel_bresp;
        m1_bvalid = sel_bvalid;
      end
      default: ;
    endcase
  end

  assign b_fire = sel_bvalid && sel_bready;

  always_comb begin
    a_bready_onehot: assert ($onehot0({s0_bready, s1_bready, s2_bready}));
  end

endmodule

`default_nettype wire

//--- logic/w_router.sv
`timescale 1ns/1ps
`default_nettype none

module w_router
  import axi_xbar_pkg::*;
  import axi_write_lock_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  aw_fire,
  input  slave_sel_t            aw_slave,
  input  master_sel_t           aw_master,
  input  logic [DATA_WIDTH-1:0] m0_wdata,
  input  logic                  m0_wlast,
  input  logic                  m0_wvalid,
  output logic                  m0_wready,
  input  logic [DATA_WIDTH-1:0] m1_wdata,
  input  logic                  m1_wlast,
  input  logic                  m1_wvalid,
  output logic                  m1_wready,
  output logic [DATA_WIDTH-1:0] s0_wdata,
  output logic                  s0_wlast,
  output logic                  s0_wvalid,
  input  logic                  s0_wready,
  output logic [DATA_WIDTH-1:0] s1_wdata,
  output logic                  s1_wlast,
  output logic                  s1_wvalid,
  input  logic                  s1_wready,
  output logic [DATA_WIDTH-1:0] s2_wdata,
  output logic                  s2_wlast,
  output logic                  s2_wvalid,
  input  logic                  s2_wready,
  input  logic                  b_fire,
  output write_lock_t           lock
);

  write_lock_t           lock_next;
  master_sel_t           gnt_master;
  logic                  in_data;
  logic                  in_resp;
  logic [DATA_WIDTH-1:0] src_wdata;
  logic                  src_wlast;
  logic                  src_wvalid;
  logic                  dst_wready;
  logic                  w_last_fire;

  assign in_data = (lock == WLOCK_S0) || (lock == WLOCK_S1) || (lock == WLOCK_S2);
  assign in_resp = (lock == WLOCK_S0_WVALID) || (lock == WLOCK_S1_WVALID) ||
                   (lock == WLOCK_S2_WVALID);

  assign src_wdata  = (gnt_master == MASTER_1) ? m1_wdata : m0_wdata;
  assign src_wlast  = (gnt_master == MASTER_1) ? m1_wlast : m0_wlast;
  assign src_wvalid = in_data && ((gnt_master == MASTER_1) ? m1_wvalid : m0_wvalid);

  always_comb begin
    case (lock)
      WLOCK_S0: dst_wready = s0_wready;
      WLOCK_S1: dst_wready = s1_wready;
      WLOCK_S2: dst_wready = s2_wready;
      default:  dst_wready = 1'b0;
    endcase
  end

  assign w_last_fire = src_wvalid && dst_wready && src_wlast;

  assign m0_wready = in_data && (gnt_master == MASTER_0) && dst_wready;
  assign m1_wready = in_data && (gnt_master == MASTER_1) && dst_wready;

  assign s0_wdata  = src_wdata;
  assign s0_wlast  = src_wlast;
  assign s0_wvalid = src_wvalid && (lock == WLOCK_S0);
  assign s1_wdata  = src_wdata;
  assign s1_wlast  = src_wlast;
  assign s1_wvalid = src_wvalid && (lock == WLOCK_S1);
  assign s2_wdata  = src_wdata;
  assign s2_wlast  = src_wlast;
  assign s2_wvalid = src_wvalid && (lock == WLOCK_S2);

  always_comb begin
    lock_next = lock;
    case (lock)
      WLOCK_NO: begin
        if (aw_fire) begin
          case (aw_slave)
            SLAVE_0: lock_next = WLOCK_S0;
            SLAVE_1: lock_next = WLOCK_S1;
            default: lock_next = WLOCK_S2;
          endcase
        end
      end
      WLOCK_S0: if (w_last_fire) lock_next = WLOCK_S0_WVALID;
      WLOCK_S1: if (w_last_fire) lock_next = WLOCK_S1_WVALID;
      WLOCK_S2: if (w_last_fire) lock_next = WLOCK_S2_WVALID;
      default:  if (b_fire) lock_next = WLOCK_NO;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lock <= WLOCK_NO;
      gnt_master <= MASTER_0;
    end else begin
      lock <= lock_next;
      if (aw_fire)
        gnt_master <= aw_master;
    end
  end

  // Response states hold until the B transfer
  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_resp && !b_fire |=> lock == $past(lock));

  a_no_w_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (lock == WLOCK_NO) |-> !(s0_wvalid || s1_wvalid || s2_wvalid));

endmodule

`default_nettype wire

//--- tb/tb_axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_xbar
  import axi_xbar_pkg::*;
();

  localparam int ID_WIDTH = 4;
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int SID_WIDTH = ID_WIDTH + TAG_BITS;
  localparam int N_TXN = 64;
  localparam int LIMIT = N_TXN * 40;

  typedef struct {
    int                    master;
    logic [ADDR_WIDTH-1:0] addr;
    logic [ID_WIDTH-1:0]   id;
    logic [7:0]            len;
    logic [DATA_WIDTH-1:0] sum;
    logic [ID_WIDTH-1:0]   bid;
    resp_t                 bresp;
    logic                  other_bvalid;
  } mtxn_t;

  typedef struct {
    slave_sel_t            slv;
    logic [SID_WIDTH-1:0]  sid;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            len;
    int                    beats;
    logic [DATA_WIDTH-1:0] sum;
  } stxn_t;

  logic clk;
  logic rst_n;

  // Master side, indexed by master number
  logic [ID_WIDTH-1:0]   awid_m[2];
  logic [ADDR_WIDTH-1:0] awaddr_m[2];
  logic [7:0]            awlen_m[2];
  logic                  awvalid_m[2];
  logic                  awready_m[2];
  logic [DATA_WIDTH-1:0] wdata_m[2];
  logic                  wlast_m[2];
  logic                  wvalid_m[2];
  logic                  wready_m[2];
  logic [ID_WIDTH-1:0]   bid_m[2];
  logic [1:0]            bresp_m[2];
  logic                  bvalid_m[2];
  logic                  bready_m[2];

  logic [SID_WIDTH-1:0]  s0_awid, s1_awid, s2_awid;
  logic [ADDR_WIDTH-1:0] s0_awaddr, s1_awaddr, s2_awaddr;
  logic [7:0]            s0_awlen, s1_awlen, s2_awlen;
  logic                  s0_awvalid, s1_awvalid, s2_awvalid;
  logic                  s0_awready, s1_awready, s2_awready;
  logic [DATA_WIDTH-1:0] s0_wdata, s1_wdata, s2_wdata;
  logic                  s0_wlast, s1_wlast, s2_wlast;
  logic                  s0_wvalid, s1_wvalid, s2_wvalid;
  logic                  s0_wready, s1_wready, s2_wready;
  logic [SID_WIDTH-1:0]  s0_bid, s1_bid, s2_bid;
  logic [1:0]            s0_bresp, s1_bresp, s2_bresp;
  logic                  s0_bvalid, s1_bvalid, s2_bvalid;
  logic                  s0_bready, s1_bready, s2_bready;
  logic [1:0]            dly[3];

  logic [31:0] lfsr;
  int          errors;
  int          cycles;
  int          n_done;
  mtxn_t       mq[$];
  stxn_t       sq[$];
  stxn_t       cur;

  axi_write_xbar #(
    .ID_WIDTH(ID_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) uut (
    .m0_awid(awid_m[0]), .m0_awaddr(awaddr_m[0]), .m0_awlen(awlen_m[0]),
    .m0_awvalid(awvalid_m[0]), .m0_awready(awready_m[0]),
    .m0_wdata(wdata_m[0]), .m0_wlast(wlast_m[0]), .m0_wvalid(wvalid_m[0]),
    .m0_wready(wready_m[0]), .m0_bid(bid_m[0]), .m0_bresp(bresp_m[0]),
    .m0_bvalid(bvalid_m[0]), .m0_bready(bready_m[0]),
    .m1_awid(awid_m[1]), .m1_awaddr(awaddr_m[1]), .m1_awlen(awlen_m[1]),
    .m1_awvalid(awvalid_m[1]), .m1_awready(awready_m[1]),
    .m1_wdata(wdata_m[1]), .m1_wlast(wlast_m[1]), .m1_wvalid(wvalid_m[1]),
    .m1_wready(wready_m[1]), .m1_bid(bid_m[1]), .m1_bresp(bresp_m[1]),
    .m1_bvalid(bvalid_m[1]), .m1_bready(bready_m[1]),
    .*
  );

  xbar_slave_model #(.SID_WIDTH(SID_WIDTH), .RESP(RESP_OKAY)) slave0 (
    .clk(clk), .rst_n(rst_n), .dly(dly[0]),
    .awid(s0_awid), .awvalid(s0_awvalid), .awready(s0_awready),
    .wlast(s0_wlast), .wvalid(s0_wvalid), .wready(s0_wready),
    .bid(s0_bid), .bresp(s0_bresp), .bvalid(s0_bvalid), .bready(s0_bready)
  );

  xbar_slave_model #(.SID_WIDTH(SID_WIDTH), .RESP(RESP_EXOKAY)) slave1 (
    .clk(clk), .rst_n(rst_n), .dly(dly[1]),
    .awid(s1_awid), .awvalid(s1_awvalid), .awready(s1_awready),
    .wlast(s1_wlast), .wvalid(s1_wvalid), .wready(s1_wready),
    .bid(s1_bid), .bresp(s1_bresp), .bvalid(s1_bvalid), .bready(s1_bready)
  );

  xbar_slave_model #(.SID_WIDTH(SID_WIDTH), .RESP(RESP_SLVERR)) slave2 (
    .clk(clk), .rst_n(rst_n), .dly(dly[2]),
    .awid(s2_awid), .awvalid(s2_awvalid), .awready(s2_awready),
    .wlast(s2_wlast), .wvalid(s2_wvalid), .wready(s2_wready),
    .bid(s2_bid), .bresp(s2_bresp), .bvalid(s2_bvalid), .bready(s2_bready)
  );

  always #4 clk = ~clk;

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Expected routing, slave-side ID and response for one write
  function automatic void ref_write(input logic [ADDR_WIDTH-1:0] addr,
                                    input logic [ID_WIDTH-1:0] id, input int m,
                                    output slave_sel_t slv, output resp_t rsp,
                                    output logic [ID_WIDTH-1:0] rid,
                                    output logic [SID_WIDTH-1:0] sid);
    case (addr[17:16])
      2'd0: begin
        slv = SLAVE_0;
        rsp = RESP_OKAY;
      end
      2'd1: begin
        slv = SLAVE_1;
        rsp = RESP_EXOKAY;
      end
      default: begin
        slv = SLAVE_2;
        rsp = RESP_SLVERR;
      end
    endcase
    rid = id;
    sid = {id, TAG_BITS'(m)};
  endfunction

  task automatic check_slave(input string name, input slave_sel_t exp, input slave_sel_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_id(input string name, input logic [SID_WIDTH-1:0] exp,
                          input logic [SID_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                            input logic [ADDR_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_sum(input string name, input logic [DATA_WIDTH-1:0] exp,
                           input logic [DATA_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic write_txn(input int m, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [ID_WIDTH-1:0] id, input logic [7:0] len,
                           input int stall);
    mtxn_t t;
    logic [DATA_WIDTH-1:0] d;
    t.master = m;
    t.addr = addr;
    t.id = id;
    t.len = len;
    t.sum = '0;
    awid_m[m] = id;
    awaddr_m[m] = addr;
    awlen_m[m] = len;
    awvalid_m[m] = 1'b1;
    do @(posedge clk); while (!awready_m[m]);
    #1 awvalid_m[m] = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      d = rand_bits(DATA_WIDTH);
      t.sum += d;
      wdata_m[m] = d;
      wlast_m[m] = (b == int'(len));
      wvalid_m[m] = 1'b1;
      do @(posedge clk); while (!wready_m[m]);
      #1;
    end
    wvalid_m[m] = 1'b0;
    wlast_m[m] = 1'b0;
    // Hold bready low a while once the response shows up
    do @(posedge clk); while (!bvalid_m[m]);
    repeat (stall) @(posedge clk);
    #1 bready_m[m] = 1'b1;
    @(posedge clk);
    t.bid = bid_m[m];
    t.bresp = resp_t'(bresp_m[m]);
    t.other_bvalid = bvalid_m[1-m];
    #1 bready_m[m] = 1'b0;
    mq.push_back(t);
  endtask

  task automatic random_txn(input int m);
    logic [ADDR_WIDTH-1:0] addr;
    logic [ID_WIDTH-1:0]   id;
    logic [7:0]            len;
    int                    stall;
    addr = rand_bits(ADDR_WIDTH);
    id = ID_WIDTH'(rand_bits(ID_WIDTH));
    len = 8'(rand_bits(3));
    stall = int'(rand_bits(3));
    for (int k = 0; k < 3; k++)
      dly[k] = 2'(rand_bits(2));
    write_txn(m, addr, id, len, stall);
  endtask

  task automatic idle_check();
    if (awready_m[0] || awready_m[1] || wready_m[0] || wready_m[1] ||
        bvalid_m[0] || bvalid_m[1] || s0_awvalid || s1_awvalid || s2_awvalid ||
        s0_wvalid || s1_wvalid || s2_wvalid || s0_bready || s1_bready || s2_bready) begin
      $display("A valid or ready output is high after reset with no request");
      errors++;
    end
  endtask

  task automatic record_beat(input logic [DATA_WIDTH-1:0] d, input logic last);
    cur.beats++;
    cur.sum += d;
    if (last)
      sq.push_back(cur);
  endtask

  // Slave-side monitor
  always @(posedge clk) begin
    int  aw_fires;
    logic stall;
    if (rst_n) begin
      aw_fires = 0;
      if (s0_awvalid && s0_awready) begin
        cur = '{SLAVE_0, s0_awid, s0_awaddr, s0_awlen, 0, '0};
        aw_fires++;
      end
      if (s1_awvalid && s1_awready) begin
        cur = '{SLAVE_1, s1_awid, s1_awaddr, s1_awlen, 0, '0};
        aw_fires++;
      end
      if (s2_awvalid && s2_awready) begin
        cur = '{SLAVE_2, s2_awid, s2_awaddr, s2_awlen, 0, '0};
        aw_fires++;
      end
      if (aw_fires > 1) begin
        $display("More than one slave took an AW transfer in one cycle");
        errors++;
      end
      if (s0_wvalid && s0_wready)
        record_beat(s0_wdata, s0_wlast);
      if (s1_wvalid && s1_wready)
        record_beat(s1_wdata, s1_wlast);
      if (s2_wvalid && s2_wready)
        record_beat(s2_wdata, s2_wlast);
      stall = (bvalid_m[0] && !bready_m[0]) || (bvalid_m[1] && !bready_m[1]);
      if (stall && aw_fires != 0) begin
        $display("An AW transfer happened while a response was stalled");
        errors++;
      end
      if (stall && (s0_bready || s1_bready || s2_bready)) begin
        $display("A slave bready is high while the master holds bready low");
        errors++;
      end
      if (bvalid_m[0] && bvalid_m[1]) begin
        $display("Both masters see bvalid at once");
        errors++;
      end
    end
  end

  // Pairs master and slave records in transfer order
  always @(posedge clk) begin
    mtxn_t                mt;
    stxn_t                st;
    slave_sel_t           es;
    resp_t                er;
    logic [ID_WIDTH-1:0]  eid;
    logic [SID_WIDTH-1:0] esid;
    if (mq.size() > 0 && sq.size() > 0) begin
      mt = mq.pop_front();
      st = sq.pop_front();
      ref_write(mt.addr, mt.id, mt.master, es, er, eid, esid);
      check_slave("slave select", es, st.slv);
      check_id("slave awid", esid, st.sid);
      check_addr("slave awaddr", mt.addr, st.addr);
      check_count("slave awlen", int'(mt.len), int'(st.len));
      check_count("beat count", int'(mt.len) + 1, st.beats);
      check_sum("wdata sum", mt.sum, st.sum);
      check_resp("bresp", er, mt.bresp);
      check_id("bid", SID_WIDTH'(eid), SID_WIDTH'(mt.bid));
      if (mt.other_bvalid) begin
        $display("The other master saw bvalid during a response");
        errors++;
      end
      // First 16 writes alternate between the masters
      if (n_done < 16 && mt.master != n_done % 2) begin
        $display("** Error grant order: expected %0d, actual %0d", n_done % 2, mt.master);
        errors++;
      end
      n_done++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles with %0d writes checked", cycles, n_done);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    lfsr = 32'h2095;
    errors = 0;
    cycles = 0;
    n_done = 0;
    for (int m = 0; m < 2; m++) begin
      awid_m[m] = '0;
      awaddr_m[m] = '0;
      awlen_m[m] = '0;
      awvalid_m[m] = 1'b0;
      wdata_m[m] = '0;
      wlast_m[m] = 1'b0;
      wvalid_m[m] = 1'b0;
      bready_m[m] = 1'b0;
    end
    for (int k = 0; k < 3; k++)
      dly[k] = 2'd0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (4) begin
      @(posedge clk);
      idle_check();
    end
    #1;
    // Two writes per master keep both requesting across grants
    repeat (4) begin
      fork
        begin
          random_txn(0);
          random_txn(0);
        end
        begin
          random_txn(1);
          random_txn(1);
        end
      join
    end
    repeat (N_TXN - 16)
      random_txn(int'(rand_bits(1)));
    while (mq.size() > 0 || sq.size() > 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Checked %0d writes, %0d errors", n_done, errors);
    if (errors == 0 && n_done == N_TXN)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/xbar_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_slave_model
  import axi_xbar_pkg::*;
#(
  parameter int SID_WIDTH = 8,
  parameter resp_t RESP = RESP_OKAY
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [1:0]            dly,
  input  logic [SID_WIDTH-1:0]  awid,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic                  wlast,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [SID_WIDTH-1:0]  bid,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready
);

  int                   st;
  int                   cnt;
  logic [SID_WIDTH-1:0] id_q;

  // 0 waits for AW, 1 takes data, 2 returns the response
  initial begin
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bid = '0;
    bresp = 2'b00;
    st = 0;
    cnt = 0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        st = 0;
        cnt = 0;
      end else if (st == 0) begin
        if (awvalid && awready) begin
          id_q = awid;
          st = 1;
          cnt = 0;
          #1 awready = 1'b0;
        end else if (awvalid) begin
          if (cnt >= int'(dly))
            #1 awready = 1'b1;
          else
            cnt++;
        end
      end else if (st == 1) begin
        if (wvalid && wready) begin
          if (wlast) begin
            st = 2;
            cnt = 0;
            #1 wready = 1'b0;
          end
        end else if (cnt >= int'(dly)) begin
          #1 wready = 1'b1;
        end else begin
          cnt++;
        end
      end else begin
        if (bvalid && bready) begin
          st = 0;
          cnt = 0;
          #1 bvalid = 1'b0;
        end else if (!bvalid) begin
          if (cnt >= int'(dly)) begin
            #1;
            bvalid = 1'b1;
            bid = id_q;
            bresp = RESP;
          end else begin
            cnt++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
